//--- Bender.yml
package:
  name: reservoir

sources:
  - reservoir_cfg_pkg.sv
  - reservoir_io_pkg.sv
  - reservoir_node.sv
  - dac_spi_driver.sv
  - adc_spi_sampler.sv
  - nonlinear_interface.sv
  - reservoir_core.sv
  - target: simulation
    files:
      - tb_reservoir.sv

//--- adc_spi_sampler.sv
`timescale 1ns/100ps

module adc_spi_sampler
    import reservoir_cfg_pkg::*;
    import reservoir_io_pkg::*;
#(
    parameter int SCLK_DIV = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  sdo,
    output logic [conv_width-1:0] word,
    output logic                  done,
    output adc_pins_t             pins
);

    localparam int div_w = $clog2(SCLK_DIV + 1);
    localparam int bit_w = $clog2(conv_width);

    typedef enum logic [1:0] {
        adc_idle,
        adc_shift,
        adc_end
    } adc_state_t;

    adc_state_t       state;
    logic [div_w-1:0] div_cnt;
    logic [bit_w-1:0] bit_cnt;
    logic             div_tick;
    logic             sclk_rise;

    assign div_tick  = (div_cnt == div_w'(SCLK_DIV - 1));
    assign sclk_rise = (state == adc_shift) && div_tick && !pins.sclk;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= adc_idle;
            div_cnt <= '0;
            bit_cnt <= '0;
            done    <= 1'b0;
            pins    <= adc_pins_idle;
        end else begin
            done <= 1'b0;
            case (state)
                adc_idle: begin
                    if (start) begin
                        pins.cs_n <= 1'b0;                  // Begin conversion.
                        pins.sclk <= 1'b0;
                        div_cnt   <= '0;
                        bit_cnt   <= '0;
                        state     <= adc_shift;
                    end
                end
                adc_shift: begin
                    if (div_tick) begin
                        div_cnt   <= '0;
                        pins.sclk <= ~pins.sclk;
                        if (pins.sclk) begin
                            if (bit_cnt == bit_w'(conv_width - 1)) begin
                                pins.cs_n <= 1'b1;
                                state     <= adc_end;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: begin
                    done  <= 1'b1;                          // One cycle after cs_n.
                    state <= adc_idle;
                end
            endcase
        end
    end

    // MSB arrives first, so the word fills from the bottom.
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            word <= {word[conv_width-2:0], sdo};
        end
    end

endmodule

//--- dac_spi_driver.sv
`timescale 1ns/100ps

module dac_spi_driver
    import reservoir_cfg_pkg::*;
    import reservoir_io_pkg::*;
#(
    parameter int SCLK_DIV = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic [conv_width-1:0] code,
    output logic                  done,
    output dac_pins_t             pins
);

    localparam int div_w = $clog2(SCLK_DIV + 1);
    localparam int bit_w = $clog2(conv_width);

    typedef enum logic [1:0] {
        dac_idle,
        dac_shift,
        dac_gap,
        dac_strobe
    } dac_state_t;

    dac_state_t            state;
    logic [div_w-1:0]      div_cnt;
    logic [bit_w-1:0]      bit_cnt;
    logic [conv_width-1:0] shreg;
    logic                  div_tick;
    logic                  sclk_fall;

    assign div_tick  = (div_cnt == div_w'(SCLK_DIV - 1));
    assign sclk_fall = (state == dac_shift) && div_tick && pins.sclk;

    // ============================================================
    // Control FSM
    // ============================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= dac_idle;
            div_cnt <= '0;
            bit_cnt <= '0;
            done    <= 1'b0;
            pins    <= dac_pins_idle;
        end else begin
            done <= 1'b0;
            case (state)
                dac_idle: begin
                    if (start) begin
                        pins.cs_n <= 1'b0;
                        pins.sclk <= 1'b0;
                        pins.din  <= code[conv_width-1];    // MSB set up early.
                        div_cnt   <= '0;
                        bit_cnt   <= '0;
                        state     <= dac_shift;
                    end
                end
                dac_shift: begin
                    if (div_tick) begin
                        div_cnt   <= '0;
                        pins.sclk <= ~pins.sclk;
                        if (sclk_fall) begin
                            pins.din <= shreg[conv_width-2];
                            if (bit_cnt == bit_w'(conv_width - 1)) begin
                                pins.cs_n <= 1'b1;
                                state     <= dac_gap;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                dac_gap: begin
                    pins.ldac_n <= 1'b0;                    // Update DAC output.
                    div_cnt     <= '0;
                    state       <= dac_strobe;
                end
                default: begin
                    if (div_tick) begin
                        pins.ldac_n <= 1'b1;
                        done        <= 1'b1;
                        state       <= dac_idle;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dac_idle && start) begin
            shreg <= code;
        end else if (sclk_fall) begin
            shreg <= shreg << 1;
        end
    end

endmodule

//--- nonlinear_interface.sv
`timescale 1ns/100ps

module nonlinear_interface
    import reservoir_cfg_pkg::*;
    import reservoir_io_pkg::*;
#(
    parameter int SCLK_DIV = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic [conv_width-1:0] code,
    output logic [conv_width-1:0] result,
    output logic                  done,
    output dac_pins_t             dac,
    output adc_pins_t             adc,
    input  logic                  adc_sdo
);

    logic                  dac_done;
    logic                  adc_start;
    logic                  adc_done;
    logic [conv_width-1:0] adc_word;

    // ============================================================
    // Round trip: DAC write, then ADC read
    // ============================================================

    dac_spi_driver #(
        .SCLK_DIV(SCLK_DIV)
    ) u_dac (
        .clk  (clk),
        .rst  (rst),
        .start(start),
        .code (code),
        .done (dac_done),
        .pins (dac)
    );

    adc_spi_sampler #(
        .SCLK_DIV(SCLK_DIV)
    ) u_adc (
        .clk  (clk),
        .rst  (rst),
        .start(adc_start),
        .sdo  (adc_sdo),
        .word (adc_word),
        .done (adc_done),
        .pins (adc)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            adc_start <= 1'b0;
            done      <= 1'b0;
        end else begin
            adc_start <= dac_done;                  // Read once the DAC has settled.
            done      <= adc_done;
        end
    end

    always_ff @(posedge clk) begin
        if (adc_done) begin
            result <= adc_word;
        end
    end

endmodule

//--- reservoir_cfg_pkg.sv
package reservoir_cfg_pkg;

    // ============================================================
    // Datapath widths
    // ============================================================

    localparam int node_width = 12;         // Default virtual node word.
    localparam int data_width = 32;         // Host sample and dout width.
    localparam int conv_width = 16;         // DAC and ADC word width.

    // Node memory settles this many cycles before a conversion starts.
    localparam int mem_wait_cycles = 3;

    // ============================================================
    // Types
    // ============================================================

    typedef logic [node_width-1:0] node_word_t;

    typedef enum logic [1:0] {
        step_idle      = 2'd0,              // Chain stable, host may step.
        step_mem_wait  = 2'd1,              // Fixed settle delay.
        step_func_wait = 2'd2               // Round trip through the analog element.
    } step_state_t;

endpackage

//--- reservoir_core.sv
`timescale 1ns/100ps

module reservoir_core
    import reservoir_cfg_pkg::*;
    import reservoir_io_pkg::*;
#(
    parameter int NUM_NODES  = 10,
    parameter int NODE_WIDTH = node_width,
    parameter int SCLK_DIV   = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         en,
    input  logic [data_width-1:0]        din,
    input  logic                         load_node,
    input  logic [NODE_WIDTH-1:0]        load_node_din,
    input  logic [$clog2(NUM_NODES)-1:0] node_sel,
    output logic [NODE_WIDTH-1:0]        node_dout,
    output logic [data_width-1:0]        dout,
    output logic                         reservoir_valid,
    output logic [NODE_WIDTH-1:0]        asic_function_out,
    output dac_pins_t                    dac,
    output adc_pins_t                    adc,
    input  logic                         adc_sdo
);

    localparam int mem_w = $clog2(mem_wait_cycles + 1);

    step_state_t           state;
    step_state_t           state_next;
    logic [mem_w-1:0]      mem_cnt;
    logic                  step_accept;
    logic                  fn_start;
    logic                  fn_done;
    logic                  shift_en;
    logic [conv_width-1:0] feedback;
    logic [conv_width-1:0] code_q;
    logic [conv_width-1:0] fn_result;
    logic [NODE_WIDTH-1:0] fn_node;
    logic [NODE_WIDTH-1:0] asic_q;
    logic [NODE_WIDTH-1:0] node_val [NUM_NODES];

    // ============================================================
    // Step controller
    // ============================================================

    assign step_accept     = (state == step_idle) && en;
    assign reservoir_valid = (state == step_idle);

    always_comb begin
        state_next = state;
        fn_start   = 1'b0;
        shift_en   = 1'b0;
        case (state)
            step_idle: begin
                if (en) begin
                    state_next = step_mem_wait;
                end
            end
            step_mem_wait: begin
                if (mem_cnt == mem_w'(mem_wait_cycles - 1)) begin
                    fn_start   = 1'b1;
                    state_next = step_func_wait;
                end
            end
            step_func_wait: begin
                if (fn_done) begin
                    shift_en   = 1'b1;              // Response enters node 0.
                    state_next = step_idle;
                end
            end
            default: state_next = step_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= step_idle;
            mem_cnt <= '0;
            asic_q  <= '0;
        end else begin
            state <= state_next;
            if (state == step_mem_wait) begin
                mem_cnt <= mem_cnt + 1'b1;
            end else begin
                mem_cnt <= '0;
            end
            if (fn_done) begin
                asic_q <= fn_node;
            end
        end
    end

    // ============================================================
    // Feedback adder and node chain
    // ============================================================

    assign feedback = conv_width'(node_val[NUM_NODES-1]) << 2;    // Last node times 4.

    // Captured at step entry so the DAC code stays put for the whole step.
    always_ff @(posedge clk) begin
        if (step_accept) begin
            code_q <= din[conv_width-1:0] + feedback;
        end
    end

    assign fn_node = fn_result[conv_width-1 -: NODE_WIDTH];

    for (genvar i = 0; i < NUM_NODES; i++) begin : g_node
        logic                  load_hit;
        logic [NODE_WIDTH-1:0] prev;

        assign load_hit = load_node && (node_sel == i);

        if (i == 0) begin : g_head
            assign prev = fn_node;
        end else begin : g_link
            assign prev = node_val[i-1];
        end

        reservoir_node #(
            .NODE_WIDTH(NODE_WIDTH)
        ) u_node (
            .clk       (clk),
            .rst       (rst),
            .shift_en  (shift_en),
            .load      (load_hit),
            .load_value(load_node_din),
            .prev_value(prev),
            .value     (node_val[i])
        );
    end

    nonlinear_interface #(
        .SCLK_DIV(SCLK_DIV)
    ) u_nonlinear (
        .clk    (clk),
        .rst    (rst),
        .start  (fn_start),
        .code   (code_q),
        .result (fn_result),
        .done   (fn_done),
        .dac    (dac),
        .adc    (adc),
        .adc_sdo(adc_sdo)
    );

    // Host side outputs.
    assign node_dout         = node_val[node_sel];
    assign dout              = data_width'(node_val[NUM_NODES-1]) << 4;
    assign asic_function_out = asic_q;

endmodule

//--- reservoir_io_pkg.sv
package reservoir_io_pkg;

    // ============================================================
    // Serial converter pin groups
    // ============================================================

    typedef struct packed {
        logic cs_n;                         // Chip select, active low.
        logic ldac_n;                       // Load strobe, active low.
        logic din;                          // Serial data to the DAC.
        logic sclk;
    } dac_pins_t;

    // ADC data comes back on a separate adc_sdo line.
    typedef struct packed {
        logic cs_n;
        logic sclk;
    } adc_pins_t;

    localparam dac_pins_t dac_pins_idle = '{
        cs_n:   1'b1,
        ldac_n: 1'b1,
        din:    1'b0,
        sclk:   1'b0
    };

    localparam adc_pins_t adc_pins_idle = '{
        cs_n: 1'b1,
        sclk: 1'b0
    };

endpackage

//--- reservoir_node.sv
`timescale 1ns/100ps

module reservoir_node
    import reservoir_cfg_pkg::*;
#(
    parameter int NODE_WIDTH = node_width
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  shift_en,
    input  logic                  load,
    input  logic [NODE_WIDTH-1:0] load_value,
    input  logic [NODE_WIDTH-1:0] prev_value,
    output logic [NODE_WIDTH-1:0] value
);

    // One tap of the delay line. A host load takes priority over a shift
    // landing in the same cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            value <= '0;
        end else if (load) begin
            value <= load_value;
        end else if (shift_en) begin
            value <= prev_value;                // Move down the chain.
        end
    end

endmodule

//--- reservoir_testdata.txt
# Columns: L node value | S din | E din stray_din | C node expected, all hex.
# E sends a second en with stray_din while the step is still running.
L 0 123
L 5 a5a
L 9 fff
C 0 123
C 5 a5a
C 9 fff
S 00000010
C 0 400
C 1 123
C 6 a5a
C 9 000
L 9 abc
C 9 abc
S 1234ffff
S ffff8000
S 0000f123
S 7fffc000
C 0 e96
C 5 123
C 9 000
E 00000100 0000ffff
C 0 010
C 1 e96

//--- sources.f
reservoir_cfg_pkg.sv
reservoir_io_pkg.sv
reservoir_node.sv
dac_spi_driver.sv
adc_spi_sampler.sv
nonlinear_interface.sv
reservoir_core.sv
tb_reservoir.sv

//--- tb_reservoir.sv
`timescale 1ns/100ps

module tb_reservoir
    import reservoir_cfg_pkg::*;
    import reservoir_io_pkg::*;
();

    localparam int num_nodes   = 10;
    localparam int step_cycles = 200;
    localparam int base_cycles = 1000;

    logic                  clk;
    logic                  rst;
    logic                  en;
    logic [data_width-1:0] din;
    logic                  load_node;
    logic [node_width-1:0] load_node_din;
    logic [3:0]            node_sel;
    logic [node_width-1:0] node_dout;
    logic [data_width-1:0] dout;
    logic                  reservoir_valid;
    logic [node_width-1:0] asic_function_out;
    dac_pins_t             dac;
    adc_pins_t             adc;
    logic                  adc_sdo;

    logic [node_width-1:0] model [num_nodes];   // Reference copy of the chain.
    logic [node_width-1:0] asic_exp;
    int                    error_count = 0;
    int                    check_count = 0;
    int                    cycle_count = 0;
    int                    cycle_limit = base_cycles;
    step_state_t           core_state;

    reservoir_core dut (
        .clk              (clk),
        .rst              (rst),
        .en               (en),
        .din              (din),
        .load_node        (load_node),
        .load_node_din    (load_node_din),
        .node_sel         (node_sel),
        .node_dout        (node_dout),
        .dout             (dout),
        .reservoir_valid  (reservoir_valid),
        .asic_function_out(asic_function_out),
        .dac              (dac),
        .adc              (adc),
        .adc_sdo          (adc_sdo)
    );

    assign core_state = dut.state;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles with the core in %s",
                     cycle_count, core_state.name());
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ============================================================
    // Loopback model of the analog element
    // ============================================================

    logic [conv_width-1:0] dac_shift;
    logic [conv_width-1:0] analog_word;
    int                    adc_bit;
    logic                  dac_sclk;
    logic                  dac_cs_n;
    logic                  dac_ldac_n;
    logic                  dac_din;
    logic                  adc_sclk;
    logic                  adc_cs_n;

    assign dac_sclk   = dac.sclk;
    assign dac_cs_n   = dac.cs_n;
    assign dac_ldac_n = dac.ldac_n;
    assign dac_din    = dac.din;
    assign adc_sclk   = adc.sclk;
    assign adc_cs_n   = adc.cs_n;

    always @(posedge dac_sclk) begin
        if (!dac_cs_n) begin
            dac_shift = {dac_shift[conv_width-2:0], dac_din};
        end
    end

    always @(negedge dac_ldac_n) analog_word = dac_shift;   // Output updates on the strobe.

    always @(negedge adc_cs_n) begin
        adc_bit = conv_width - 1;
        adc_sdo = analog_word[adc_bit];
    end

    always @(negedge adc_sclk) begin
        if (!adc_cs_n && adc_bit > 0) begin
            adc_bit--;
            adc_sdo = analog_word[adc_bit];
        end
    end

    // ============================================================
    // Checks and reference model
    // ============================================================

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [31:0] expected_dout();
        return 32'(model[num_nodes-1]) << 4;
    endfunction

    task automatic check_node(input int idx, input logic [node_width-1:0] exp);
        @(negedge clk);
        node_sel = idx[3:0];
        @(posedge clk);
        compare($sformatf("node_dout[%0d]", idx), node_dout, exp);
    endtask

    task automatic check_chain();
        for (int i = 0; i < num_nodes; i++) begin
            check_node(i, model[i]);
        end
        compare("dout", dout, expected_dout());
        compare("asic_function_out", asic_function_out, asic_exp);
        compare("reservoir_valid", reservoir_valid, 1);
    endtask

    task automatic check_reset();
        @(posedge clk);
        compare("reservoir_valid", reservoir_valid, 1);
        compare("dac.cs_n", dac.cs_n, 1);
        compare("dac.ldac_n", dac.ldac_n, 1);
        compare("dac.sclk", dac.sclk, 0);
        compare("adc.cs_n", adc.cs_n, 1);
        compare("adc.sclk", adc.sclk, 0);
        compare("dout", dout, 0);
        for (int i = 0; i < num_nodes; i++) begin
            check_node(i, 0);
        end
    endtask

    task automatic write_node(input int idx, input logic [node_width-1:0] value);
        @(negedge clk);
        load_node     = 1'b1;
        node_sel      = idx[3:0];
        load_node_din = value;
        @(negedge clk);
        load_node = 1'b0;
        model[idx] = value;
    endtask

    task automatic run_step(input logic [31:0] sample, input bit stray,
                            input logic [31:0] stray_sample);
        logic [conv_width-1:0] code;
        while (!reservoir_valid) @(posedge clk);
        @(negedge clk);
        en  = 1'b1;
        din = sample;
        @(negedge clk);
        en = 1'b0;
        compare("reservoir_valid", reservoir_valid, 0);
        if (stray) begin                        // Core is busy here, so this en is dropped.
            @(negedge clk);
            en  = 1'b1;
            din = stray_sample;
            @(negedge clk);
            en = 1'b0;
        end
        @(posedge clk);
        while (!reservoir_valid) @(posedge clk);
        code = sample[conv_width-1:0] + {model[num_nodes-1], 2'b00};
        for (int i = num_nodes - 1; i > 0; i--) begin
            model[i] = model[i-1];
        end
        model[0] = code[conv_width-1 -: node_width];
        asic_exp = model[0];
        check_chain();
    endtask

    // ============================================================
    // Test data replay
    // ============================================================

    task automatic read_command(input int fd, output logic [7:0] cmd, output logic [31:0] a,
                                output logic [31:0] b, output bit ok);
        logic [8*8-1:0]  tok;
        logic [8*80-1:0] rest;
        int              n;
        bit              searching;
        ok        = 1'b0;
        cmd       = 8'h00;
        a         = '0;
        b         = '0;
        searching = 1'b1;
        while (searching) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) begin
                searching = 1'b0;
            end else if (tok == "#") begin
                n = $fgets(rest, fd);           // Skip the rest of a comment line.
            end else begin
                cmd = tok[7:0];
                case (cmd)
                    "S":           n = $fscanf(fd, "%h", a);
                    "L", "C", "E": n = $fscanf(fd, "%h %h", a, b);
                    default:       n = 0;
                endcase
                ok        = 1'b1;
                searching = 1'b0;
            end
        end
    endtask

    task automatic count_steps(input int fd, output int steps);
        logic [7:0]  cmd;
        logic [31:0] a;
        logic [31:0] b;
        bit          ok;
        steps = 0;
        ok    = 1'b1;
        while (ok) begin
            read_command(fd, cmd, a, b, ok);
            if (ok && (cmd == "S" || cmd == "E")) begin
                steps++;
            end
        end
    endtask

    task automatic run_commands(input int fd);
        logic [7:0]  cmd;
        logic [31:0] a;
        logic [31:0] b;
        bit          ok;
        ok = 1'b1;
        while (ok) begin
            read_command(fd, cmd, a, b, ok);
            if (ok) begin
                case (cmd)
                    "L": write_node(a, b[node_width-1:0]);
                    "S": run_step(a, 1'b0, '0);
                    "E": run_step(a, 1'b1, b);
                    "C": begin
                        check_node(a, b[node_width-1:0]);
                        compare($sformatf("model[%0d]", a), model[a], b);
                        compare("dout", dout, expected_dout());
                    end
                    default: begin
                        $display("Unknown command '%c' found in the test data", cmd);
                        error_count++;
                    end
                endcase
            end
        end
    endtask

    initial begin
        int fd;
        int steps;
        rst           = 1'b1;
        en            = 1'b0;
        din           = '0;
        load_node     = 1'b0;
        load_node_din = '0;
        node_sel      = '0;
        adc_sdo       = 1'b0;
        dac_shift     = '0;
        analog_word   = '0;
        adc_bit       = 0;
        asic_exp      = '0;
        for (int i = 0; i < num_nodes; i++) begin
            model[i] = '0;
        end

        fd = $fopen("reservoir_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open reservoir_testdata.txt for reading");
            error_count++;
        end else begin
            count_steps(fd, steps);
            $fclose(fd);
            cycle_limit = base_cycles + step_cycles * steps;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset();

        if (fd != 0) begin
            fd = $fopen("reservoir_testdata.txt", "r");
            run_commands(fd);
            $fclose(fd);
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
